// File: idu_pkg.sv
package idu_pkg;

    localparam int INST_ADDR_WIDTH = 32;
    localparam int INST_DATA_WIDTH = 32;
    localparam int REG_ADDR_WIDTH  = 5;
    localparam int CSR_ADDR_WIDTH  = 12;   // zero-extended to 32 at the top ports
    localparam int DECINFO_WIDTH   = 8;    // {op[4:0], grp[2:0]}

    // execution group, bits 2..0 of the decode-info bus
    localparam logic [2:0] GRP_ALU    = 3'd1;
    localparam logic [2:0] GRP_BRANCH = 3'd2;
    localparam logic [2:0] GRP_JUMP   = 3'd3;
    localparam logic [2:0] GRP_LOAD   = 3'd4;
    localparam logic [2:0] GRP_STORE  = 3'd5;
    localparam logic [2:0] GRP_CSR    = 3'd6;
    localparam logic [2:0] GRP_UPPER  = 3'd7;

    // Operation code, bits 7..3 of the decode-info bus.
    // op[2:0] is funct3, zero for the U and J formats.
    // op[3] is inst[30] for OP and shift-immediate words, zero otherwise.
    // op[4] is set for JALR and AUIPC, clear for JAL and LUI.
    localparam int OP_ALT_BIT = 3;
    localparam int OP_SEL_BIT = 4;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam int CU_BUS_WIDTH = 2;
    localparam int CU_FLUSH     = 0;  // load a bubble
    localparam int CU_STALL     = 1;  // hold current contents

    // one instruction word seen through each base format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } inst_fmt_u;

endpackage

// File: idu_dec_if.sv
`timescale 1ns/100ps

interface idu_dec_if;
    import idu_pkg::*;

    logic [INST_ADDR_WIDTH-1:0] inst_addr;
    logic [INST_DATA_WIDTH-1:0] inst;
    logic                       inst_valid;
    logic                       is_pred_branch;   // carried through only
    logic                       reg_we;
    logic [REG_ADDR_WIDTH-1:0]  reg_waddr;
    logic [REG_ADDR_WIDTH-1:0]  reg1_raddr;
    logic [REG_ADDR_WIDTH-1:0]  reg2_raddr;
    logic                       csr_we;
    logic [CSR_ADDR_WIDTH-1:0]  csr_waddr;
    logic [CSR_ADDR_WIDTH-1:0]  csr_raddr;
    logic [DECINFO_WIDTH-1:0]   dec_info_bus;
    logic [31:0]                dec_imm;
    logic                       illegal_inst;
    logic                       inst_jump;
    logic                       inst_branch;
    logic                       inst_csr_type;
    logic                       is_load;

    modport src (
        output inst_addr, inst, inst_valid, is_pred_branch,
        output reg_we, reg_waddr, reg1_raddr, reg2_raddr,
        output csr_we, csr_waddr, csr_raddr, dec_info_bus, dec_imm,
        output illegal_inst, inst_jump, inst_branch, inst_csr_type, is_load
    );

    modport dst (
        input inst_addr, inst, inst_valid, is_pred_branch,
        input reg_we, reg_waddr, reg1_raddr, reg2_raddr,
        input csr_we, csr_waddr, csr_raddr, dec_info_bus, dec_imm,
        input illegal_inst, inst_jump, inst_branch, inst_csr_type, is_load
    );

    // hazard view with the source addresses of the decoding word
    modport mon (
        input inst_valid, reg_we, reg_waddr, is_load, reg1_raddr, reg2_raddr
    );

endinterface

// File: idu_decode.sv
`timescale 1ns/100ps

module idu_decode (
    input  logic [idu_pkg::INST_DATA_WIDTH-1:0] inst_i,
    input  logic [idu_pkg::INST_ADDR_WIDTH-1:0] inst_addr_i,
    input  logic                                inst_valid_i,
    input  logic                                is_pred_branch_i,
    idu_dec_if.src                              dec
);
    import idu_pkg::*;

    inst_fmt_u   fmt;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] imm_z;
    logic [2:0]  grp;
    logic [4:0]  op;
    logic        legal;
    logic        rd_use;
    logic        csr_use;

    assign fmt = inst_i;

    // sign-extended immediates, one per format
    assign imm_i = {{20{fmt.i.imm[11]}}, fmt.i.imm};
    assign imm_s = {{20{fmt.s.imm_hi[6]}}, fmt.s.imm_hi, fmt.s.imm_lo};
    assign imm_b = {{19{fmt.b.imm12}}, fmt.b.imm12, fmt.b.imm11,
                    fmt.b.imm10_5, fmt.b.imm4_1, 1'b0};
    assign imm_u = {fmt.u.imm, 12'b0};
    assign imm_j = {{11{fmt.j.imm20}}, fmt.j.imm20, fmt.j.imm19_12,
                    fmt.j.imm11, fmt.j.imm10_1, 1'b0};
    assign imm_z = {27'b0, fmt.i.rs1};  // csr uimm sits in the rs1 field

    always_comb begin
        grp               = '0;
        op                = '0;
        legal             = 1'b1;
        rd_use            = 1'b0;
        csr_use           = 1'b0;
        dec.reg1_raddr    = '0;
        dec.reg2_raddr    = '0;
        dec.dec_imm       = '0;
        dec.inst_jump     = 1'b0;
        dec.inst_branch   = 1'b0;
        dec.inst_csr_type = 1'b0;
        dec.is_load       = 1'b0;
        case (fmt.r.opcode)
            OPC_LUI, OPC_AUIPC: begin
                grp             = GRP_UPPER;
                op[OP_SEL_BIT]  = (fmt.u.opcode == OPC_AUIPC);
                rd_use          = 1'b1;
                dec.dec_imm     = imm_u;
            end
            OPC_JAL: begin
                grp             = GRP_JUMP;
                rd_use          = 1'b1;
                dec.dec_imm     = imm_j;
                dec.inst_jump   = 1'b1;
            end
            OPC_JALR: begin
                grp             = GRP_JUMP;
                op              = {1'b1, 1'b0, fmt.i.funct3};
                rd_use          = 1'b1;
                dec.reg1_raddr  = fmt.i.rs1;
                dec.dec_imm     = imm_i;
                dec.inst_jump   = 1'b1;
            end
            OPC_BRANCH: begin
                grp             = GRP_BRANCH;
                op[2:0]         = fmt.b.funct3;
                dec.reg1_raddr  = fmt.b.rs1;
                dec.reg2_raddr  = fmt.b.rs2;
                dec.dec_imm     = imm_b;
                dec.inst_branch = 1'b1;
            end
            OPC_LOAD: begin
                grp             = GRP_LOAD;
                op[2:0]         = fmt.i.funct3;
                rd_use          = 1'b1;
                dec.reg1_raddr  = fmt.i.rs1;
                dec.dec_imm     = imm_i;
                dec.is_load     = 1'b1;
            end
            OPC_STORE: begin
                grp             = GRP_STORE;
                op[2:0]         = fmt.s.funct3;
                dec.reg1_raddr  = fmt.s.rs1;
                dec.reg2_raddr  = fmt.s.rs2;
                dec.dec_imm     = imm_s;
            end
            OPC_OPIMM: begin
                grp             = GRP_ALU;
                op[2:0]         = fmt.i.funct3;
                op[OP_ALT_BIT]  = (fmt.i.funct3[1:0] == 2'b01) && fmt.r.funct7[5];  // shifts
                rd_use          = 1'b1;
                dec.reg1_raddr  = fmt.i.rs1;
                dec.dec_imm     = imm_i;
            end
            OPC_OP: begin
                grp             = GRP_ALU;
                op              = {1'b0, fmt.r.funct7[5], fmt.r.funct3};
                rd_use          = 1'b1;
                dec.reg1_raddr  = fmt.r.rs1;
                dec.reg2_raddr  = fmt.r.rs2;
            end
            OPC_SYSTEM: begin
                if (fmt.i.funct3 == 3'b000) begin
                    legal = 1'b0;  // ecall, ebreak, xret not handled here
                end else begin
                    grp               = GRP_CSR;
                    op[2:0]           = fmt.i.funct3;
                    rd_use            = 1'b1;
                    csr_use           = 1'b1;
                    dec.inst_csr_type = 1'b1;
                    if (fmt.i.funct3[2]) begin
                        dec.dec_imm = imm_z;  // csrrwi, csrrsi, csrrci
                    end else begin
                        dec.reg1_raddr = fmt.i.rs1;
                    end
                end
            end
            default: legal = 1'b0;
        endcase
    end

    assign dec.inst_addr      = inst_addr_i;
    assign dec.inst           = inst_i;
    assign dec.inst_valid     = inst_valid_i;
    assign dec.is_pred_branch = is_pred_branch_i;
    assign dec.dec_info_bus   = {op, grp};
    assign dec.reg_we         = inst_valid_i && legal && rd_use;
    assign dec.reg_waddr      = rd_use ? fmt.r.rd : '0;
    assign dec.csr_we         = inst_valid_i && csr_use;  // csr_use implies legal
    assign dec.csr_waddr      = csr_use ? fmt.i.imm : '0;
    assign dec.csr_raddr      = csr_use ? fmt.i.imm : '0;
    assign dec.illegal_inst   = inst_valid_i && !legal;

endmodule

// File: idu_pipe_ctrl.sv
`timescale 1ns/100ps

module idu_pipe_ctrl (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             flush_req_i,   // redirect from execute
    input  logic                             ex_stall_i,    // execute busy
    idu_dec_if.mon                           dec,
    idu_dec_if.mon                           ex,
    output logic [idu_pkg::CU_BUS_WIDTH-1:0] stall_flag_o,
    output logic                             fetch_hold_o
);
    import idu_pkg::*;

    logic ex_load;
    logic rs1_hit;
    logic rs2_hit;
    logic load_use;

    // load in ex writing a real register
    assign ex_load = ex.inst_valid && ex.is_load && ex.reg_we && (ex.reg_waddr != '0);

    assign rs1_hit  = (dec.reg1_raddr != '0) && (dec.reg1_raddr == ex.reg_waddr);
    assign rs2_hit  = (dec.reg2_raddr != '0) && (dec.reg2_raddr == ex.reg_waddr);
    assign load_use = ex_load && dec.inst_valid && (rs1_hit || rs2_hit);

    always_comb begin
        stall_flag_o = '0;
        fetch_hold_o = 1'b0;
        if (flush_req_i) begin
            stall_flag_o[CU_FLUSH] = 1'b1;  // redirect wins and fetch moves on
        end else if (ex_stall_i) begin
            stall_flag_o[CU_STALL] = 1'b1;
            fetch_hold_o           = 1'b1;
        end else if (load_use) begin
            stall_flag_o[CU_FLUSH] = 1'b1;  // bubble into ex
            fetch_hold_o           = 1'b1;  // same word again next cycle
        end
    end

    a_flush_stall_excl: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !(stall_flag_o[CU_FLUSH] && stall_flag_o[CU_STALL])
    );

    a_no_hold_on_redirect: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        flush_req_i |-> !fetch_hold_o
    );

endmodule

// File: idu_id_pipe.sv
`timescale 1ns/100ps

module idu_id_pipe (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic [idu_pkg::CU_BUS_WIDTH-1:0] stall_flag_i,
    idu_dec_if.dst                           d,
    idu_dec_if.src                           q
);
    import idu_pkg::*;

    logic flush_en;
    logic stall_en;

    assign flush_en = stall_flag_i[CU_FLUSH];
    assign stall_en = stall_flag_i[CU_STALL];

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_en) begin  // flush beats stall
            q.inst_addr      <= '0;
            q.inst           <= '0;
            q.inst_valid     <= 1'b0;
            q.is_pred_branch <= 1'b0;
            q.reg_we         <= 1'b0;
            q.reg_waddr      <= '0;
            q.reg1_raddr     <= '0;
            q.reg2_raddr     <= '0;
            q.csr_we         <= 1'b0;
            q.csr_waddr      <= '0;
            q.csr_raddr      <= '0;
            q.dec_info_bus   <= '0;
            q.dec_imm        <= '0;
            q.illegal_inst   <= 1'b0;
            q.inst_jump      <= 1'b0;
            q.inst_branch    <= 1'b0;
            q.inst_csr_type  <= 1'b0;
            q.is_load        <= 1'b0;
        end else if (!stall_en) begin
            q.inst_addr      <= d.inst_addr;
            q.inst           <= d.inst;
            q.inst_valid     <= d.inst_valid;
            q.is_pred_branch <= d.is_pred_branch;
            q.reg_we         <= d.reg_we;
            q.reg_waddr      <= d.reg_waddr;
            q.reg1_raddr     <= d.reg1_raddr;
            q.reg2_raddr     <= d.reg2_raddr;
            q.csr_we         <= d.csr_we;
            q.csr_waddr      <= d.csr_waddr;
            q.csr_raddr      <= d.csr_raddr;
            q.dec_info_bus   <= d.dec_info_bus;
            q.dec_imm        <= d.dec_imm;
            q.illegal_inst   <= d.illegal_inst;
            q.inst_jump      <= d.inst_jump;
            q.inst_branch    <= d.inst_branch;
            q.inst_csr_type  <= d.inst_csr_type;
            q.is_load        <= d.is_load;
        end
    end

    // execute never sees a live slot right after a flush
    a_flush_bubble: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        flush_en |=> !q.inst_valid
    );

endmodule

// File: idu_top.sv
`timescale 1ns/100ps

module idu_top (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic [idu_pkg::INST_DATA_WIDTH-1:0] inst_i,
    input  logic [idu_pkg::INST_ADDR_WIDTH-1:0] inst_addr_i,
    input  logic                                inst_valid_i,
    input  logic                                is_pred_branch_i,
    input  logic                                flush_req_i,
    input  logic                                ex_stall_i,
    output logic                                fetch_hold_o,
    output logic [idu_pkg::INST_ADDR_WIDTH-1:0] inst_addr_o,
    output logic [idu_pkg::INST_DATA_WIDTH-1:0] inst_o,
    output logic                                inst_valid_o,
    output logic                                reg_we_o,
    output logic [idu_pkg::REG_ADDR_WIDTH-1:0]  reg_waddr_o,
    output logic [idu_pkg::REG_ADDR_WIDTH-1:0]  reg1_raddr_o,
    output logic [idu_pkg::REG_ADDR_WIDTH-1:0]  reg2_raddr_o,
    output logic                                csr_we_o,
    output logic [31:0]                         csr_waddr_o,
    output logic [31:0]                         csr_raddr_o,
    output logic [idu_pkg::DECINFO_WIDTH-1:0]   dec_info_bus_o,
    output logic [31:0]                         dec_imm_o,
    output logic                                is_pred_branch_o,
    output logic                                illegal_inst_o,
    output logic                                inst_jump_o,
    output logic                                inst_branch_o,
    output logic                                inst_csr_type_o
);
    import idu_pkg::*;

    logic [CU_BUS_WIDTH-1:0] stall_flag;

    idu_dec_if dec_bus ();  // decoder to ID/EX register
    idu_dec_if ex_bus ();   // ID/EX register to execute

    idu_decode u_decode (
        .inst_i           (inst_i),
        .inst_addr_i      (inst_addr_i),
        .inst_valid_i     (inst_valid_i),
        .is_pred_branch_i (is_pred_branch_i),
        .dec              (dec_bus.src)
    );

    idu_pipe_ctrl u_pipe_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_req_i  (flush_req_i),
        .ex_stall_i   (ex_stall_i),
        .dec          (dec_bus.mon),
        .ex           (ex_bus.mon),
        .stall_flag_o (stall_flag),
        .fetch_hold_o (fetch_hold_o)
    );

    idu_id_pipe u_id_pipe (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .stall_flag_i (stall_flag),
        .d            (dec_bus.dst),
        .q            (ex_bus.src)
    );

    assign inst_addr_o      = ex_bus.inst_addr;
    assign inst_o           = ex_bus.inst;
    assign inst_valid_o     = ex_bus.inst_valid;
    assign reg_we_o         = ex_bus.reg_we;
    assign reg_waddr_o      = ex_bus.reg_waddr;
    assign reg1_raddr_o     = ex_bus.reg1_raddr;
    assign reg2_raddr_o     = ex_bus.reg2_raddr;
    assign csr_we_o         = ex_bus.csr_we;
    assign csr_waddr_o      = {{(32-CSR_ADDR_WIDTH){1'b0}}, ex_bus.csr_waddr};
    assign csr_raddr_o      = {{(32-CSR_ADDR_WIDTH){1'b0}}, ex_bus.csr_raddr};
    assign dec_info_bus_o   = ex_bus.dec_info_bus;
    assign dec_imm_o        = ex_bus.dec_imm;
    assign is_pred_branch_o = ex_bus.is_pred_branch;
    assign illegal_inst_o   = ex_bus.illegal_inst;
    assign inst_jump_o      = ex_bus.inst_jump;
    assign inst_branch_o    = ex_bus.inst_branch;
    assign inst_csr_type_o  = ex_bus.inst_csr_type;

endmodule

// File: tb_idu_ref.svh
`ifndef TB_IDU_REF_SVH
`define TB_IDU_REF_SVH

// expected contents of the ID/EX register, as seen on the ex ports
typedef struct packed {
    logic [31:0] inst_addr;
    logic [31:0] inst;
    logic        inst_valid;
    logic        is_pred_branch;
    logic        reg_we;
    logic [4:0]  reg_waddr;
    logic [4:0]  reg1_raddr;
    logic [4:0]  reg2_raddr;
    logic        csr_we;
    logic [31:0] csr_waddr;
    logic [31:0] csr_raddr;
    logic [7:0]  dec_info_bus;
    logic [31:0] dec_imm;
    logic        illegal_inst;
    logic        inst_jump;
    logic        inst_branch;
    logic        inst_csr_type;
    logic        is_load;
} ex_fields_t;

// replicate bit msb upward
function automatic logic [31:0] sign_ext(input logic [31:0] v, input int msb);
    logic signed [31:0] t;
    t = v << (31 - msb);
    return t >>> (31 - msb);
endfunction

function automatic ex_fields_t ref_decode(input logic [31:0] word, input logic [31:0] addr,
                                          input logic valid, input logic pred);
    inst_fmt_u  f;
    ex_fields_t e;
    logic       legal;
    logic       writes_rd;
    logic       csr;
    logic [2:0] grp;
    logic [4:0] op;
    f         = word;
    e         = '0;
    legal     = 1'b1;
    writes_rd = 1'b0;
    csr       = 1'b0;
    grp       = 3'd0;
    op        = 5'd0;
    e.inst_addr      = addr;
    e.inst           = word;
    e.inst_valid     = valid;
    e.is_pred_branch = pred;
    case (f.r.opcode)
        OPC_LUI: begin
            grp       = GRP_UPPER;
            writes_rd = 1'b1;
            e.dec_imm = {f.u.imm, 12'h000};
        end
        OPC_AUIPC: begin
            grp       = GRP_UPPER;
            op        = 5'b10000;  // auipc marker
            writes_rd = 1'b1;
            e.dec_imm = {f.u.imm, 12'h000};
        end
        OPC_JAL: begin
            grp         = GRP_JUMP;
            writes_rd   = 1'b1;
            e.inst_jump = 1'b1;
            e.dec_imm   = sign_ext({11'b0, f.j.imm20, f.j.imm19_12, f.j.imm11,
                                    f.j.imm10_1, 1'b0}, 20);
        end
        OPC_JALR: begin
            grp          = GRP_JUMP;
            op           = {2'b10, f.i.funct3};
            writes_rd    = 1'b1;
            e.inst_jump  = 1'b1;
            e.reg1_raddr = f.i.rs1;
            e.dec_imm    = sign_ext({20'b0, f.i.imm}, 11);
        end
        OPC_BRANCH: begin
            grp           = GRP_BRANCH;
            op            = {2'b00, f.b.funct3};
            e.inst_branch = 1'b1;
            e.reg1_raddr  = f.b.rs1;
            e.reg2_raddr  = f.b.rs2;
            e.dec_imm     = sign_ext({19'b0, f.b.imm12, f.b.imm11, f.b.imm10_5,
                                      f.b.imm4_1, 1'b0}, 12);
        end
        OPC_LOAD: begin
            grp          = GRP_LOAD;
            op           = {2'b00, f.i.funct3};
            writes_rd    = 1'b1;
            e.is_load    = 1'b1;
            e.reg1_raddr = f.i.rs1;
            e.dec_imm    = sign_ext({20'b0, f.i.imm}, 11);
        end
        OPC_STORE: begin
            grp          = GRP_STORE;
            op           = {2'b00, f.s.funct3};
            e.reg1_raddr = f.s.rs1;
            e.reg2_raddr = f.s.rs2;
            e.dec_imm    = sign_ext({20'b0, f.s.imm_hi, f.s.imm_lo}, 11);
        end
        OPC_OPIMM: begin
            grp          = GRP_ALU;
            op           = {1'b0, 1'b0, f.i.funct3};
            if (f.i.funct3 == 3'b001 || f.i.funct3 == 3'b101)
                op[3] = word[30];  // slli, srli, srai
            writes_rd    = 1'b1;
            e.reg1_raddr = f.i.rs1;
            e.dec_imm    = sign_ext({20'b0, f.i.imm}, 11);
        end
        OPC_OP: begin
            grp          = GRP_ALU;
            op           = {1'b0, word[30], f.r.funct3};
            writes_rd    = 1'b1;
            e.reg1_raddr = f.r.rs1;
            e.reg2_raddr = f.r.rs2;
        end
        OPC_SYSTEM: begin
            if (f.i.funct3 == 3'b000) begin
                legal = 1'b0;
            end else begin
                grp             = GRP_CSR;
                op              = {2'b00, f.i.funct3};
                writes_rd       = 1'b1;
                csr             = 1'b1;
                e.inst_csr_type = 1'b1;
                if (f.i.funct3[2])
                    e.dec_imm = {27'b0, f.i.rs1};  // zimm
                else
                    e.reg1_raddr = f.i.rs1;
            end
        end
        default: legal = 1'b0;
    endcase
    e.dec_info_bus = {op, grp};
    e.reg_we       = valid && legal && writes_rd;
    e.reg_waddr    = writes_rd ? f.r.rd : 5'd0;
    e.csr_we       = valid && csr;
    e.csr_waddr    = csr ? {20'b0, f.i.imm} : 32'h0;
    e.csr_raddr    = csr ? {20'b0, f.i.imm} : 32'h0;
    e.illegal_inst = valid && !legal;
    return e;
endfunction

// load in ex whose destination is read by the word now in decode
function automatic logic load_use_hazard(input ex_fields_t ex, input ex_fields_t dc);
    logic in_flight;
    in_flight = ex.inst_valid && ex.is_load && ex.reg_we && (ex.reg_waddr != 5'd0);
    return in_flight && dc.inst_valid &&
           ((dc.reg1_raddr != 5'd0 && dc.reg1_raddr == ex.reg_waddr) ||
            (dc.reg2_raddr != 5'd0 && dc.reg2_raddr == ex.reg_waddr));
endfunction

`endif

// File: tb_idu_top.sv
`timescale 1ns/100ps

module tb_idu_top;
    import idu_pkg::*;

    `include "tb_idu_ref.svh"

    localparam int CLK_PERIOD = 100;
    localparam int N_RAND     = 160;
    localparam int N_ILLEGAL  = 24;
    localparam int N_FLUSH    = 16;
    localparam int N_STALL    = 16;
    localparam int N_HAZARD   = 16;
    localparam int N_TESTS    = N_RAND + N_ILLEGAL + 2 * (N_FLUSH + N_STALL + N_HAZARD) + 2;

    logic        clk = 1'b0;
    logic        rst_n_i;
    logic [31:0] inst_i;
    logic [31:0] inst_addr_i;
    logic        inst_valid_i;
    logic        is_pred_branch_i;
    logic        flush_req_i;
    logic        ex_stall_i;
    logic        fetch_hold_o;
    logic [31:0] inst_addr_o;
    logic [31:0] inst_o;
    logic        inst_valid_o;
    logic        reg_we_o;
    logic [4:0]  reg_waddr_o;
    logic [4:0]  reg1_raddr_o;
    logic [4:0]  reg2_raddr_o;
    logic        csr_we_o;
    logic [31:0] csr_waddr_o;
    logic [31:0] csr_raddr_o;
    logic [7:0]  dec_info_bus_o;
    logic [31:0] dec_imm_o;
    logic        is_pred_branch_o;
    logic        illegal_inst_o;
    logic        inst_jump_o;
    logic        inst_branch_o;
    logic        inst_csr_type_o;

    logic [15:0] lfsr = 16'd49460;
    logic [31:0] pc = 32'h0000_1000;
    ex_fields_t  exp_q = '0;  // model of the ID/EX register
    ex_fields_t  dec_now;
    logic        hazard;
    logic        hold_exp;

    idu_top UUT (
        .clk (clk), .rst_n_i (rst_n_i), .inst_i (inst_i), .inst_addr_i (inst_addr_i),
        .inst_valid_i (inst_valid_i), .is_pred_branch_i (is_pred_branch_i),
        .flush_req_i (flush_req_i), .ex_stall_i (ex_stall_i), .fetch_hold_o (fetch_hold_o),
        .inst_addr_o (inst_addr_o), .inst_o (inst_o), .inst_valid_o (inst_valid_o),
        .reg_we_o (reg_we_o), .reg_waddr_o (reg_waddr_o), .reg1_raddr_o (reg1_raddr_o),
        .reg2_raddr_o (reg2_raddr_o), .csr_we_o (csr_we_o), .csr_waddr_o (csr_waddr_o),
        .csr_raddr_o (csr_raddr_o), .dec_info_bus_o (dec_info_bus_o), .dec_imm_o (dec_imm_o),
        .is_pred_branch_o (is_pred_branch_o), .illegal_inst_o (illegal_inst_o),
        .inst_jump_o (inst_jump_o), .inst_branch_o (inst_branch_o),
        .inst_csr_type_o (inst_csr_type_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw(input int n, output logic [31:0] r);
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [6:0] table_opcode(input logic [3:0] sel);
        case (sel)
            4'd0:    return OPC_LUI;
            4'd1:    return OPC_AUIPC;
            4'd2:    return OPC_JAL;
            4'd3, 4'd10: return OPC_JALR;
            4'd4, 4'd11: return OPC_BRANCH;
            4'd5, 4'd12: return OPC_LOAD;  // loads weighted up for hazards
            4'd6, 4'd13: return OPC_STORE;
            4'd7, 4'd14: return OPC_OPIMM;
            4'd8, 4'd15: return OPC_OP;
            default: return OPC_SYSTEM;
        endcase
    endfunction

    task automatic legal_word(output logic [31:0] w);
        logic [31:0] sel;
        logic [31:0] body;
        draw(4, sel);
        draw(25, body);
        w = {body[24:0], table_opcode(sel[3:0])};
        if (w[6:0] == OPC_SYSTEM && w[14:12] == 3'b000)
            w[14:12] = 3'b001;  // keep it a csr op
    endtask

    task automatic illegal_word(output logic [31:0] w);
        ex_fields_t probe;
        draw(32, w);
        probe = ref_decode(w, 32'h0, 1'b1, 1'b0);
        if (!probe.illegal_inst) begin
            w[6:0]   = OPC_SYSTEM;  // ecall-like and not handled
            w[14:12] = 3'b000;
        end
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("FAILED %s: got %h expected %h at %0t", name, got, want, $time);
            $display("Something failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic compare_outputs(input ex_fields_t e);
        check("inst_addr_o", inst_addr_o, e.inst_addr);
        check("inst_o", inst_o, e.inst);
        check("inst_valid_o", 32'(inst_valid_o), 32'(e.inst_valid));
        check("is_pred_branch_o", 32'(is_pred_branch_o), 32'(e.is_pred_branch));
        check("reg_we_o", 32'(reg_we_o), 32'(e.reg_we));
        check("reg_waddr_o", 32'(reg_waddr_o), 32'(e.reg_waddr));
        check("reg1_raddr_o", 32'(reg1_raddr_o), 32'(e.reg1_raddr));
        check("reg2_raddr_o", 32'(reg2_raddr_o), 32'(e.reg2_raddr));
        check("csr_we_o", 32'(csr_we_o), 32'(e.csr_we));
        check("csr_waddr_o", csr_waddr_o, e.csr_waddr);
        check("csr_raddr_o", csr_raddr_o, e.csr_raddr);
        check("dec_info_bus_o", 32'(dec_info_bus_o), 32'(e.dec_info_bus));
        check("dec_imm_o", dec_imm_o, e.dec_imm);
        check("illegal_inst_o", 32'(illegal_inst_o), 32'(e.illegal_inst));
        check("inst_jump_o", 32'(inst_jump_o), 32'(e.inst_jump));
        check("inst_branch_o", 32'(inst_branch_o), 32'(e.inst_branch));
        check("inst_csr_type_o", 32'(inst_csr_type_o), 32'(e.inst_csr_type));
    endtask

    // outputs settled and inputs equal to what the next edge samples
    always @(negedge clk) begin
        compare_outputs(exp_q);
        dec_now  = ref_decode(inst_i, inst_addr_i, inst_valid_i, is_pred_branch_i);
        hazard   = load_use_hazard(exp_q, dec_now);
        hold_exp = !flush_req_i && (ex_stall_i || hazard);
        check("fetch_hold_o", 32'(fetch_hold_o), 32'(hold_exp));
        if (!rst_n_i || flush_req_i || (hazard && !ex_stall_i))
            exp_q = '0;  // bubble
        else if (!ex_stall_i)
            exp_q = dec_now;
    end

    // one fetch slot repeated while the stage asks fetch to hold
    task automatic issue_slot(input logic [31:0] word, input logic valid,
                              input logic flush, input logic stall);
        logic [31:0] r;
        logic        held;
        draw(1, r);
        @(posedge clk);
        #10;
        inst_i           = word;
        inst_addr_i      = pc;
        inst_valid_i     = valid;
        is_pred_branch_i = r[0];
        flush_req_i      = flush;
        ex_stall_i       = stall;
        @(negedge clk);
        held = fetch_hold_o;
        while (held) begin
            @(posedge clk);
            #10;
            flush_req_i = 1'b0;
            ex_stall_i  = 1'b0;
            @(negedge clk);
            held = fetch_hold_o;
        end
        pc = pc + 32'd4;
    endtask

    initial begin
        #(CLK_PERIOD * (N_TESTS * 20 + 200));
        $display("watchdog expired before the stimulus completed");
        $display("Something failed");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] w;
        logic [31:0] r;
        logic [4:0]  rd;
        rst_n_i          = 1'b0;
        inst_i           = '0;
        inst_addr_i      = '0;
        inst_valid_i     = 1'b0;
        is_pred_branch_i = 1'b0;
        flush_req_i      = 1'b0;
        ex_stall_i       = 1'b0;
        repeat (10) @(posedge clk);
        #10;
        rst_n_i = 1'b1;

        for (int k = 0; k < N_RAND; k++) begin
            legal_word(w);
            draw(3, r);
            issue_slot(w, r[2:0] != 3'd0, 1'b0, 1'b0);  // about one in eight empty
        end
        for (int k = 0; k < N_ILLEGAL; k++) begin
            illegal_word(w);
            issue_slot(w, 1'b1, 1'b0, 1'b0);
        end
        for (int k = 0; k < N_FLUSH; k++) begin
            legal_word(w);
            issue_slot(w, 1'b1, 1'b0, 1'b0);
            legal_word(w);
            issue_slot(w, 1'b1, 1'b1, 1'b0);  // redirect drops this word
        end
        for (int k = 0; k < N_STALL; k++) begin
            legal_word(w);
            issue_slot(w, 1'b1, 1'b0, 1'b0);
            legal_word(w);
            issue_slot(w, 1'b1, 1'b0, 1'b1);
        end
        for (int k = 0; k < N_HAZARD; k++) begin
            draw(5, r);
            rd = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
            legal_word(w);
            w[6:0]  = OPC_LOAD;
            w[11:7] = rd;
            issue_slot(w, 1'b1, 1'b0, 1'b0);
            legal_word(w);
            w[6:0] = ((k % 2) == 1) ? OPC_STORE : OPC_OP;  // both read rs1 and rs2
            if ((k % 4) < 2)
                w[19:15] = rd;
            else
                w[24:20] = rd;
            issue_slot(w, 1'b1, 1'b0, 1'b0);
        end
        issue_slot(32'h0, 1'b0, 1'b0, 1'b0);
        issue_slot(32'h0, 1'b0, 1'b0, 1'b0);

        @(negedge clk);
        @(posedge clk);
        $display("Everything OK");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+.
idu_pkg.sv
idu_dec_if.sv
idu_decode.sv
idu_pipe_ctrl.sv
idu_id_pipe.sv
idu_top.sv
tb_idu_top.sv

// File: Makefile
TOP = tb_idu_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module idu_top

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	@if grep -q "Something failed" sim.log; then \
		echo "simulation reported a failure, see sim.log"; exit 1; \
	elif ! grep -q "Everything OK" sim.log; then \
		echo "simulation ended without a result, see sim.log"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf obj_dir sim.log
